//--- hw/conv_pkg.sv
// ==================================================
// Geometry fixed to a 28x28 image in 14x14 quads and 32 filters
// Changing a constant here does not resize the block grid by itself
// ==================================================
package conv_pkg;

    // Image and block grid
    localparam int QUAD_COLS      = 14;  // Quads per image row
    localparam int BLOCKS_PER_ROW = 13;
    localparam int NUM_BLOCKS     = 169;

    // Filters and parameter layout
    localparam int NUM_FILTERS       = 32;
    localparam int PARAMS_PER_FILTER = 10;  // Bias then 9 weights
    localparam int BEATS_PER_BLOCK   = 11;

    // PE command values
    localparam logic [7:0] MAC_COUNT = 8'd9;
    localparam logic [7:0] SSFR_CMD  = 8'b11000001;
    localparam logic [7:0] SSFR_CFG  = 8'b00101000;
    localparam int         PE_LATENCY = 2;

    // Residue storage holds one word per block and filter
    localparam int RES_FILTER_STRIDE = 43;
    localparam int RES_DEPTH         = NUM_FILTERS * RES_FILTER_STRIDE;

    typedef logic [7:0] pixel_t;
    typedef logic [7:0] img_addr_t;
    typedef logic [8:0] conv_addr_t;
    typedef logic [10:0] res_addr_t;
    typedef logic [7:0] block_idx_t;
    typedef logic [4:0] filter_idx_t;
    typedef logic [3:0] step_t;

    typedef enum logic [1:0] {BEAT_HEADER, BEAT_WINDOW, BEAT_SSFR} beat_kind_t;
    typedef enum logic [1:0] {IDLE, RUN, DONE} ctrl_state_t;

    // Pixels of one 2x2 quad in raster order
    typedef struct packed {
        pixel_t p0;
        pixel_t p1;
        pixel_t p2;
        pixel_t p3;
    } quad_t;

    typedef struct packed {
        logic       valid;
        beat_kind_t kind;
        pixel_t     px0;
        pixel_t     px1;
        pixel_t     px2;
        pixel_t     px3;
        pixel_t     param;
    } pe_beat_t;

endpackage

//--- hw/res_bank.sv
// ==================================================
// Registered read without read-during-write bypass
// ==================================================
module res_bank
    import conv_pkg::*;
(
    input  logic      clk,
    input  logic      wr_en,
    input  res_addr_t wr_addr,
    input  pixel_t    wr_data,
    input  res_addr_t rd_addr,
    output pixel_t    rd_data
);

    pixel_t mem [RES_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
        rd_data <= mem[rd_addr];  // Old data on a same-address write
    end

endmodule

//--- hw/layer_ctrl.sv
// ==================================================
// Start is only taken in IDLE; done waits for the last write-back
// ==================================================
module layer_ctrl
    import conv_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  logic        block_done,
    input  logic        wb_idle,
    output logic        block_go,
    output block_idx_t  cur_block,
    output filter_idx_t cur_filter,
    output logic        busy,
    output logic        done
);

    ctrl_state_t state;
    logic        last_block;
    logic        last_filter;

    assign last_block  = (cur_block == block_idx_t'(NUM_BLOCKS - 1));
    assign last_filter = (cur_filter == filter_idx_t'(NUM_FILTERS - 1));
    assign busy        = (state != IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            block_go   <= 1'b0;
            done       <= 1'b0;
            cur_block  <= '0;
            cur_filter <= '0;
        end else begin
            block_go <= 1'b0;
            done     <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state      <= RUN;
                        block_go   <= 1'b1;
                        cur_block  <= '0;
                        cur_filter <= '0;
                    end
                end
                RUN: begin
                    if (block_done) begin
                        if (!last_block) begin
                            cur_block <= cur_block + 1'b1;
                            block_go  <= 1'b1;
                        end else begin
                            cur_block <= '0;
                            if (last_filter) begin
                                state <= DONE;  // Wait for final result write
                            end else begin
                                cur_filter <= cur_filter + 1'b1;
                                block_go   <= 1'b1;
                            end
                        end
                    end
                end
                DONE: begin
                    if (wb_idle) begin
                        done  <= 1'b1;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_go_in_run: assert property (@(posedge clk) disable iff (reset)
        block_go |-> state == RUN);

endmodule

//--- hw/block_fetch.sv
// ==================================================
// Image memory must return data one cycle after the address
// ==================================================
module block_fetch
    import conv_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        block_go,
    input  block_idx_t  cur_block,
    output img_addr_t   img_addr,
    input  quad_t       img_quad,
    output quad_t [3:0] tile,
    output logic        tile_ready
);

    logic [3:0] blk_row;
    logic [3:0] blk_col;
    logic [3:0] quad_row;
    logic [3:0] quad_col;
    logic       fetching;
    logic [1:0] fetch_idx;  // 0 TL, 1 TR, 2 BL, 3 BR quad
    logic       cap_valid;
    logic [1:0] cap_idx;

    // Address phase then data phase
    always_ff @(posedge clk) begin
        if (reset) begin
            fetching  <= 1'b0;
            fetch_idx <= '0;
            cap_valid <= 1'b0;
        end else begin
            cap_valid <= fetching;
            if (block_go) begin
                fetching  <= 1'b1;
                fetch_idx <= '0;
            end else if (fetching) begin
                fetch_idx <= fetch_idx + 1'b1;
                if (fetch_idx == 2'd3)
                    fetching <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (block_go) begin
            blk_row <= 4'(cur_block / BLOCKS_PER_ROW);
            blk_col <= 4'(cur_block % BLOCKS_PER_ROW);
        end
        cap_idx <= fetch_idx;
        if (cap_valid)
            tile[cap_idx] <= img_quad;
    end

    assign quad_row   = blk_row + 4'(fetch_idx[1]);
    assign quad_col   = blk_col + 4'(fetch_idx[0]);
    assign img_addr   = img_addr_t'(quad_row) * img_addr_t'(QUAD_COLS) + img_addr_t'(quad_col);
    assign tile_ready = cap_valid && (cap_idx == 2'd3);  // Last quad lands this cycle

    a_addr_range: assert property (@(posedge clk) disable iff (reset)
        fetching |-> img_addr < img_addr_t'(QUAD_COLS * QUAD_COLS));

    a_tile_time: assert property (@(posedge clk) disable iff (reset)
        block_go |-> ##5 tile_ready);

endmodule

//--- hw/beat_emitter.sv
// ==================================================
// Parameter memory has a one-cycle read; no back-pressure from the PE
// ==================================================
module beat_emitter
    import conv_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        tile_ready,
    input  quad_t [3:0] tile,
    input  filter_idx_t cur_filter,
    output conv_addr_t  conv_addr,
    input  pixel_t      conv_param,
    output pe_beat_t    beat,
    output logic        block_done,
    output logic        ssfr_strobe
);

    localparam step_t LAST_STEP = step_t'(BEATS_PER_BLOCK - 1);

    step_t      step;
    step_t      win_k;
    logic [1:0] win_r;
    logic [1:0] win_c;
    logic       active;
    logic       last_beat;
    conv_addr_t param_base;

    // Pixel (y,x) of the 4x4 tile
    function automatic pixel_t tile_pixel(
        input quad_t [3:0] t,
        input logic [1:0]  y,
        input logic [1:0]  x
    );
        quad_t q;
        q = t[{y[1], x[1]}];
        case ({y[0], x[0]})
            2'd0:    return q.p0;
            2'd1:    return q.p1;
            2'd2:    return q.p2;
            default: return q.p3;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            step   <= '0;
        end else if (tile_ready) begin
            active <= 1'b1;
            step   <= '0;
        end else if (active) begin
            step <= step + 1'b1;
            if (step == LAST_STEP)
                active <= 1'b0;
        end
    end

    // Address runs one beat ahead so the read data meets its beat
    assign param_base = conv_addr_t'(cur_filter) * conv_addr_t'(PARAMS_PER_FILTER);
    assign conv_addr  = param_base + (active ? conv_addr_t'(step) + 9'd1 : 9'd0);

    always_comb begin
        win_k = step - 1'b1;
        win_r = 2'(win_k / 3);
        win_c = 2'(win_k % 3);
        beat  = '0;
        if (active) begin
            beat.valid = 1'b1;
            if (step == '0) begin
                beat.kind  = BEAT_HEADER;
                beat.px1   = MAC_COUNT;
                beat.param = conv_param;  // Bias
            end else if (step == LAST_STEP) begin
                beat.kind  = BEAT_SSFR;
                beat.px0   = SSFR_CMD;
                beat.param = SSFR_CFG;
            end else begin
                beat.kind  = BEAT_WINDOW;
                beat.px0   = tile_pixel(tile, win_r, win_c);
                beat.px1   = tile_pixel(tile, win_r, win_c + 2'd1);
                beat.px2   = tile_pixel(tile, win_r + 2'd1, win_c);
                beat.px3   = tile_pixel(tile, win_r + 2'd1, win_c + 2'd1);
                beat.param = conv_param;  // Weight k
            end
        end
    end

    assign last_beat   = active && (step == LAST_STEP);
    assign block_done  = last_beat;
    assign ssfr_strobe = last_beat;

    a_beat_train: assert property (@(posedge clk) disable iff (reset)
        tile_ready |=> (beat.valid && beat.kind == BEAT_HEADER)
            ##1 (beat.valid && beat.kind == BEAT_WINDOW) [*9]
            ##1 (beat.valid && beat.kind == BEAT_SSFR)
            ##1 !beat.valid);

endmodule

//--- hw/res_writeback.sv
// ==================================================
// PE result is taken PE_LATENCY cycles after the SSFR beat without a valid flag
// ==================================================
module res_writeback
    import conv_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        ssfr_strobe,
    input  block_idx_t  cur_block,
    input  filter_idx_t cur_filter,
    input  pixel_t      pe_result,
    input  res_addr_t   res_rd_addr,
    output quad_t       res_rd_data,
    output logic        wb_idle
);

    logic [PE_LATENCY-1:0] strobe_dly;
    logic                  wr_pending;
    res_addr_t             wb_addr;
    logic [1:0]            wb_bank;
    pixel_t                wb_data;
    pixel_t                bank_q [4];

    always_ff @(posedge clk) begin
        if (reset) begin
            strobe_dly <= '0;
            wr_pending <= 1'b0;
        end else begin
            strobe_dly <= {strobe_dly[PE_LATENCY-2:0], ssfr_strobe};
            wr_pending <= strobe_dly[PE_LATENCY-1];
        end
    end

    // Block index picks the bank round robin
    always_ff @(posedge clk) begin
        if (ssfr_strobe) begin
            wb_addr <= res_addr_t'(cur_filter) * res_addr_t'(RES_FILTER_STRIDE)
                       + res_addr_t'(cur_block >> 2);
            wb_bank <= cur_block[1:0];
        end
        if (strobe_dly[PE_LATENCY-1])
            wb_data <= pe_result;
    end

    for (genvar b = 0; b < 4; b++) begin : g_bank
        res_bank u_bank (
            .clk     (clk),
            .wr_en   (wr_pending && (wb_bank == 2'(b))),
            .wr_addr (wb_addr),
            .wr_data (wb_data),
            .rd_addr (res_rd_addr),
            .rd_data (bank_q[b])
        );
    end

    assign res_rd_data = '{p0: bank_q[0], p1: bank_q[1], p2: bank_q[2], p3: bank_q[3]};
    assign wb_idle     = !(|strobe_dly) && !wr_pending;

    a_wr_range: assert property (@(posedge clk) disable iff (reset)
        wr_pending |-> wb_addr < res_addr_t'(RES_DEPTH));

endmodule

//--- hw/conv_layer_seq.sv
// ==================================================
// PE must accept one beat per cycle; memories read with one cycle latency
// ==================================================
module conv_layer_seq
    import conv_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    output logic       busy,
    output logic       done,
    output img_addr_t  img_addr,
    input  quad_t      img_quad,
    output conv_addr_t conv_addr,
    input  pixel_t     conv_param,
    output pe_beat_t   beat,
    input  pixel_t     pe_result,
    input  res_addr_t  res_rd_addr,
    output quad_t      res_rd_data
);

    logic        block_go;
    block_idx_t  cur_block;
    filter_idx_t cur_filter;
    logic        tile_ready;
    quad_t [3:0] tile;
    logic        block_done;
    logic        ssfr_strobe;
    logic        wb_idle;

    layer_ctrl u_ctrl (
        .clk, .reset, .start, .block_done, .wb_idle,
        .block_go, .cur_block, .cur_filter, .busy, .done
    );

    block_fetch u_fetch (
        .clk, .reset, .block_go, .cur_block,
        .img_addr, .img_quad, .tile, .tile_ready
    );

    beat_emitter u_emit (
        .clk, .reset, .tile_ready, .tile, .cur_filter,
        .conv_addr, .conv_param, .beat, .block_done, .ssfr_strobe
    );

    res_writeback u_wb (
        .clk, .reset, .ssfr_strobe, .cur_block, .cur_filter,
        .pe_result, .res_rd_addr, .res_rd_data, .wb_idle
    );

endmodule

//--- tb/tb_conv_layer_seq.sv
// ==================================================
// Image, parameter and PE models are ideal; PE result is held one cycle only
// ==================================================
module tb_conv_layer_seq
    import conv_pkg::*;
;

    localparam int TOTAL_BLOCKS = NUM_FILTERS * NUM_BLOCKS;
    localparam int DONE_TIMEOUT = TOTAL_BLOCKS * 17 + 200;

    logic       clk = 1'b0;
    logic       reset = 1'b1;
    logic       start;
    logic       busy;
    logic       done;
    img_addr_t  img_addr;
    quad_t      img_quad;
    conv_addr_t conv_addr;
    pixel_t     conv_param;
    pixel_t     pe_result;
    pe_beat_t   beat;
    res_addr_t  res_rd_addr;
    quad_t      res_rd_data;

    quad_t           image [QUAD_COLS * QUAD_COLS];
    pixel_t          params [512];
    img_addr_t [4:0] addr_hist;  // [0] is the newest address
    int              seed = 35538;
    int              errors = 0;
    int              timeouts = 0;
    int              ssfr_count = 0;
    int              beat_idx = 0;  // Position of the next beat in its block
    int              done_count = 0;
    int              lat_cnt = 0;
    pixel_t          pe_val = '0;
    bit              started = 1'b0;
    bit              timed_out = 1'b0;

    conv_layer_seq dut (
        .clk, .reset, .start, .busy, .done, .img_addr, .img_quad, .conv_addr,
        .conv_param, .beat, .pe_result, .res_rd_addr, .res_rd_data
    );

    always #2 clk = ~clk;

    // Quad address of quad (dy,dx) of a block's 2x2 quad window
    function automatic img_addr_t quad_addr(int blk, int dy, int dx);
        return img_addr_t'((blk / BLOCKS_PER_ROW + dy) * QUAD_COLS + blk % BLOCKS_PER_ROW + dx);
    endfunction

    function automatic pixel_t image_pixel(int y, int x);
        quad_t q;
        q = image[(y / 2) * QUAD_COLS + x / 2];
        return q[8 * (3 - ((y % 2) * 2 + x % 2)) +: 8];  // p0 sits in the top byte
    endfunction

    // Pixel n of window k; n runs TL, TR, BL, BR
    function automatic pixel_t window_pixel(int blk, int k, int n);
        int y;
        int x;
        y = 2 * (blk / BLOCKS_PER_ROW) + k / 3 + n / 2;
        x = 2 * (blk % BLOCKS_PER_ROW) + k % 3 + n % 2;
        return image_pixel(y, x);
    endfunction

    function automatic pixel_t param_value(int i);
        return pixel_t'(i * 3 + 1);
    endfunction

    function automatic pixel_t pe_value(int f, int b);
        return pixel_t'(f * 7 + b);
    endfunction

    task automatic log_mismatch(string msg);
        errors++;
        $display("CHECK FAILED at time %0t: %s", $time, msg);
    endtask

    task automatic note_timeout(string what);
        timeouts++;
        $display("Timeout while waiting for %s", what);
    endtask

    // Memory models with a one-cycle read
    always @(posedge clk) begin
        img_quad   <= #1 image[img_addr];
        conv_param <= #1 params[conv_addr];
    end

    // PE model drives each result for exactly one cycle
    always @(posedge clk) begin
        if (beat.valid && beat.kind == BEAT_SSFR) begin
            pe_val  <= pe_value(ssfr_count / NUM_BLOCKS, ssfr_count % NUM_BLOCKS);
            lat_cnt <= PE_LATENCY - 1;
        end else if (lat_cnt != 0) begin
            lat_cnt <= lat_cnt - 1;
        end
        if (lat_cnt == 1)
            pe_result <= #1 pe_val;
        else
            pe_result <= #1 ~pe_val;
    end

    always @(posedge clk) begin
        addr_hist <= {addr_hist[3:0], img_addr};
        if (beat.valid)
            beat_idx <= (beat.kind == BEAT_SSFR) ? 0 : beat_idx + 1;
        if (beat.valid && beat.kind == BEAT_SSFR)
            ssfr_count <= ssfr_count + 1;
        if (done)
            done_count <= done_count + 1;
    end

    quiet_before_start: assert property (@(posedge clk) disable iff (reset)
        !started |-> !beat.valid && !busy && !done)
        else log_mismatch("beat valid, busy or done active before start");

    quad_addr_order: assert property (@(posedge clk) disable iff (reset)
        (beat.valid && beat.kind == BEAT_HEADER) |->
            addr_hist[4] == quad_addr(ssfr_count % NUM_BLOCKS, 0, 0)
            && addr_hist[3] == quad_addr(ssfr_count % NUM_BLOCKS, 0, 1)
            && addr_hist[2] == quad_addr(ssfr_count % NUM_BLOCKS, 1, 0)
            && addr_hist[1] == quad_addr(ssfr_count % NUM_BLOCKS, 1, 1))
        else log_mismatch("image quad addresses out of order");

    header_fields: assert property (@(posedge clk) disable iff (reset)
        (beat.valid && beat.kind == BEAT_HEADER) |-> beat_idx == 0
            && beat.px0 == 8'd0 && beat.px1 == MAC_COUNT && beat.px2 == 8'd0
            && beat.px3 == 8'd0
            && beat.param == param_value((ssfr_count / NUM_BLOCKS) * PARAMS_PER_FILTER))
        else log_mismatch("header beat has wrong position, MAC count or bias");

    window_pixels: assert property (@(posedge clk) disable iff (reset)
        (beat.valid && beat.kind == BEAT_WINDOW) |->
            beat.px0 == window_pixel(ssfr_count % NUM_BLOCKS, beat_idx - 1, 0)
            && beat.px1 == window_pixel(ssfr_count % NUM_BLOCKS, beat_idx - 1, 1)
            && beat.px2 == window_pixel(ssfr_count % NUM_BLOCKS, beat_idx - 1, 2)
            && beat.px3 == window_pixel(ssfr_count % NUM_BLOCKS, beat_idx - 1, 3))
        else log_mismatch("window beat pixels differ from image");

    window_weight: assert property (@(posedge clk) disable iff (reset)
        (beat.valid && beat.kind == BEAT_WINDOW) |-> beat_idx >= 1 && beat_idx <= 9
            && beat.param == param_value((ssfr_count / NUM_BLOCKS) * PARAMS_PER_FILTER
                                         + beat_idx))
        else log_mismatch("window beat has wrong position or weight");

    ssfr_fields: assert property (@(posedge clk) disable iff (reset)
        (beat.valid && beat.kind == BEAT_SSFR) |-> beat_idx == 10
            && beat.px0 == SSFR_CMD && beat.param == SSFR_CFG)
        else log_mismatch("SSFR beat has wrong position or command");

    done_once: assert property (@(posedge clk) disable iff (reset)
        done |-> ssfr_count == TOTAL_BLOCKS && done_count == 0)
        else log_mismatch("done pulsed early or more than once");

    busy_ends_with_done: assert property (@(posedge clk) disable iff (reset)
        $fell(busy) |-> done)
        else log_mismatch("busy dropped without done");

    quiet_after_done: assert property (@(posedge clk) disable iff (reset)
        (done_count > 0) |-> !beat.valid && !busy)
        else log_mismatch("activity after done");

    task automatic pulse_start();
        @(posedge clk);
        #1 start = 1'b1;
        started = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
    endtask

    task automatic wait_busy_high(output bit to);
        int n = 0;
        while (!busy && n < 10) begin
            @(posedge clk);
            #1 n++;
        end
        to = !busy;
        if (to)
            note_timeout("busy after start");
    endtask

    task automatic wait_blocks(input int count, output bit to);
        int n = 0;
        while (ssfr_count < count && n < count * 17 + 40) begin
            @(posedge clk);
            #1 n++;
        end
        to = (ssfr_count < count);
        if (to)
            note_timeout("the first blocks to finish");
    endtask

    task automatic wait_done(output bit to);
        int n = 0;
        while (done_count == 0 && n < DONE_TIMEOUT) begin
            @(posedge clk);
            #1 n++;
        end
        to = (done_count == 0);
        if (to)
            note_timeout("done");
    endtask

    // Each address returns one byte per bank
    task automatic read_residue();
        quad_t got;
        int    b;
        for (int f = 0; f < NUM_FILTERS; f++) begin
            for (int w = 0; w < RES_FILTER_STRIDE; w++) begin
                @(posedge clk);
                #1 res_rd_addr = res_addr_t'(f * RES_FILTER_STRIDE + w);
                @(posedge clk);
                #1 got = res_rd_data;
                for (int j = 0; j < 4; j++) begin
                    b = 4 * w + j;
                    if (b < NUM_BLOCKS)
                        assert (got[8 * (3 - j) +: 8] == pe_value(f, b))
                        else log_mismatch($sformatf("residue filter %0d block %0d", f, b));
                end
            end
        end
    endtask

    initial begin
        start       = 1'b0;
        img_quad    = '0;
        conv_param  = '0;
        pe_result   = '0;
        res_rd_addr = '0;
        for (int i = 0; i < QUAD_COLS * QUAD_COLS; i++)
            image[i] = $random(seed);
        for (int i = 0; i < 512; i++)
            params[i] = param_value(i);
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
        repeat (20) @(posedge clk);  // Idle window before start
        pulse_start();
        wait_busy_high(timed_out);
        if (!timed_out)
            wait_blocks(3, timed_out);
        if (!timed_out) begin
            pulse_start();  // Ignored while busy
            wait_done(timed_out);
        end
        if (!timed_out) begin
            repeat (20) @(posedge clk);
            read_residue();
            assert (done_count == 1) else log_mismatch("done count is not one");
        end
        $display("Errors: %0d  Timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- flist.f
hw/conv_pkg.sv
hw/res_bank.sv
hw/layer_ctrl.sv
hw/block_fetch.sv
hw/beat_emitter.sv
hw/res_writeback.sv
hw/conv_layer_seq.sv
tb/tb_conv_layer_seq.sv

//--- Bender.yml
package:
  name: conv_layer_seq

sources:
  - files:
      - hw/conv_pkg.sv
      - hw/res_bank.sv
      - hw/layer_ctrl.sv
      - hw/block_fetch.sv
      - hw/beat_emitter.sv
      - hw/res_writeback.sv
      - hw/conv_layer_seq.sv
  - target: test
    files:
      - tb/tb_conv_layer_seq.sv
